// ==== logic/div_pkg.sv ====
// Shared types and constants for the iterative integer divider.
// Import inside a module body, or use scoped names in port lists.

package div_pkg;

   // One operand or result word
   typedef logic [31:0] word_t;

   // Partial remainder or divisor with an extra sign bit
   typedef logic [32:0] ext_t;

   // Small-number operand or quotient
   typedef logic [3:0] nib_t;

   // Iteration counter, wide enough for the run plus the fix cycle
   typedef logic [5:0] count_t;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      LOAD,
      RUN,
      FIX,
      DONE
   } div_state_t;

   // One quotient bit per cycle
   localparam count_t DIV_STEPS = 6'd32;

endpackage

// ==== logic/div_ctrl_if.sv ====
// Command and status bundle between the divider FSM and its datapath.
// The FSM connects through ctl, the datapath blocks through dp.

interface div_ctrl_if;

   // Commands from the FSM
   logic load;
   logic step;
   logic fix;
   logic use_small;

   // Status from the datapath
   logic rem_neg;
   logic small_ok;
   logic div_zero;

   modport ctl (
      output load, step, fix, use_small,
      input  rem_neg, small_ok, div_zero
   );

   modport dp (
      input  load, step, fix, use_small,
      output rem_neg, small_ok, div_zero
   );

endinterface

// ==== logic/div_ctl.sv ====
// Divider FSM: accepts an operation, sequences the iteration steps
// and the remainder fix, and raises busy, done and done_early.
// Commands leave on the ctl modport of div_ctrl_if.

module div_ctl (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    start,
   input  logic    fast_disable,
   input  logic    rem_op,
   div_ctrl_if.ctl ctrl,
   output logic    busy,
   output logic    done,
   output logic    done_early
);
   import div_pkg::*;

   div_state_t state;
   div_state_t state_nx;
   count_t     count;
   logic       rem_q;
   logic       fast_dis_q;
   logic       fast_go;

   assign busy = (state != IDLE);

   // Operands are taken on the accepting edge itself
   assign ctrl.load = start & (state == IDLE);

   // Small-number path is for quotients only
   assign fast_go = ctrl.small_ok & ~fast_dis_q & ~rem_q;

   assign ctrl.step = (state == RUN);

   // Correction only when the final partial remainder went negative
   assign ctrl.fix = (state == FIX) & ctrl.rem_neg;

   always_comb begin
      state_nx = state;
      case (state)
         IDLE: begin
            if (start) begin
               state_nx = LOAD;
            end
         end
         LOAD: state_nx = fast_go ? DONE : RUN;
         RUN: begin
            if (count == DIV_STEPS - 6'd1) begin
               state_nx = rem_q ? FIX : DONE;
            end
         end
         FIX:     state_nx = DONE;
         DONE:    state_nx = IDLE;
         default: state_nx = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state          <= IDLE;
         count          <= '0;
         rem_q          <= 1'b0;
         fast_dis_q     <= 1'b0;
         ctrl.use_small <= 1'b0;
         done           <= 1'b0;
         done_early     <= 1'b0;
      end else begin
         state      <= state_nx;
         done       <= (state_nx == DONE);
         done_early <= (state == LOAD) & fast_go;
         if (ctrl.load) begin
            rem_q      <= rem_op;
            fast_dis_q <= fast_disable;
         end
         // Path choice holds until the next operation loads
         if (state == LOAD) begin
            count          <= '0;
            ctrl.use_small <= fast_go;
         end else if (ctrl.step || state == FIX) begin
            count <= count + 6'd1;
         end
      end
   end

endmodule

// ==== logic/div_operands.sv ====
// Operand capture for the divider. On load it stores the dividend
// magnitude, the sign-extended divisor and the result sign flags,
// and reports a small-number or zero divisor to the FSM.

module div_operands #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [DATA_W-1:0] dividend,
   input  logic [DATA_W-1:0] divisor,
   input  logic              unsigned_op,
   input  logic              rem_op,
   div_ctrl_if.dp            ctrl,
   output logic [DATA_W-1:0] mag_dividend,
   output logic [DATA_W:0]   m_reg,
   output logic              neg_q,
   output logic              neg_r,
   output logic              rem_sel
);

   logic dvd_neg;
   logic dvs_neg;
   logic signed_eff;
   logic zero_q;

   assign dvd_neg = dividend[DATA_W-1];
   assign dvs_neg = divisor[DATA_W-1];

   // No sign handling for a zero divisor, so the remainder is the raw dividend
   assign signed_eff = ~unsigned_op & (divisor != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mag_dividend <= '0;
         m_reg        <= '0;
         neg_q        <= 1'b0;
         neg_r        <= 1'b0;
         rem_sel      <= 1'b0;
         zero_q       <= 1'b0;
      end else if (ctrl.load) begin
         mag_dividend <= (signed_eff & dvd_neg) ? -dividend : dividend;
         m_reg        <= {~unsigned_op & dvs_neg, divisor};
         neg_q        <= signed_eff & (dvd_neg ^ dvs_neg);
         neg_r        <= signed_eff & dvd_neg;
         rem_sel      <= rem_op;
         zero_q       <= (divisor == '0);
      end
   end

   assign ctrl.div_zero = zero_q;

   // Both operands non-negative and within a nibble, divisor non-zero
   assign ctrl.small_ok = (mag_dividend[DATA_W-1:4] == '0) &
                          (m_reg[DATA_W:4] == '0) &
                          (m_reg[3:0] != 4'd0);

endmodule

// ==== logic/div_iterate.sv ====
// Non-restoring divide datapath, one quotient bit per step.
// The quotient register starts as the dividend and shifts left, so
// the dividend bits feed the partial remainder as quotient bits enter.
// A fix command adds the divisor magnitude back to a negative remainder.

module div_iterate #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic [DATA_W-1:0] mag_dividend,
   input  logic [DATA_W:0]   m_reg,
   div_ctrl_if.dp            ctrl,
   output logic [DATA_W-1:0] quotient,
   output logic [DATA_W-1:0] remainder
);

   logic [DATA_W:0]   acc;
   logic [DATA_W:0]   acc_src;
   logic [DATA_W:0]   acc_sum;
   logic [DATA_W-1:0] q_reg;
   logic              init;
   logic              add;

   // A negative divisor flips add and subtract
   assign add = acc[DATA_W] ^ m_reg[DATA_W];

   // Fix reuses the adder on the unshifted remainder
   assign acc_src = ctrl.fix ? acc : {acc[DATA_W-1:0], q_reg[DATA_W-1]};
   assign acc_sum = add ? (acc_src + m_reg) : (acc_src - m_reg);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         init  <= 1'b0;
         acc   <= '0;
         q_reg <= '0;
      end else begin
         // Captured operands become visible one cycle after load
         init <= ctrl.load;
         if (init) begin
            acc   <= '0;
            q_reg <= mag_dividend;
         end else if (ctrl.step) begin
            acc   <= acc_sum;
            q_reg <= {q_reg[DATA_W-2:0], ~acc_sum[DATA_W]};
         end else if (ctrl.fix) begin
            acc <= acc_sum;
         end
      end
   end

   assign ctrl.rem_neg = acc[DATA_W];
   assign quotient     = q_reg;
   assign remainder    = acc[DATA_W-1:0];

endmodule

// ==== logic/div_smallnum.sv ====
// Small-number divide for the fast path: the low nibble of the
// dividend magnitude over the low nibble of the divisor.
// The answer is registered one cycle after the operands are captured.

module div_smallnum (
   input  logic           clk,
   input  logic           arst_n,
   input  div_pkg::word_t mag_dividend,
   input  div_pkg::ext_t  m_reg,
   output div_pkg::nib_t  small_q
);

   logic fits;

   // Only register when the operands are small, so a zero nibble never divides
   assign fits = ((mag_dividend >> 4) == '0) &
                 ((m_reg >> 4) == '0) &
                 (m_reg[3:0] != 4'd0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         small_q <= '0;
      end else if (fits) begin
         small_q <= mag_dividend[3:0] / m_reg[3:0];
      end
   end

endmodule

// ==== logic/div_result.sv ====
// Result stage of the divider, purely combinational.
// Applies the sign flags, forces all ones for a zero divisor and
// picks the small-number, remainder or quotient value.

module div_result #(
   parameter int DATA_W = 32
) (
   input  logic [DATA_W-1:0] quotient,
   input  logic [DATA_W-1:0] remainder,
   input  div_pkg::nib_t     small_q,
   input  logic              neg_q,
   input  logic              neg_r,
   input  logic              rem_sel,
   div_ctrl_if.dp            ctrl,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] q_pick;
   logic [DATA_W-1:0] q_final;
   logic [DATA_W-1:0] r_final;

   // Fast path answer replaces the iterated quotient
   assign q_pick = ctrl.use_small ? DATA_W'(small_q) : quotient;

   // RISC-V gives all ones for x / 0
   assign q_final = ctrl.div_zero ? '1 : (neg_q ? -q_pick : q_pick);

   // Remainder takes the dividend's sign
   assign r_final = neg_r ? -remainder : remainder;

   assign result = rem_sel ? r_final : q_final;

endmodule

// ==== logic/div_top.sv ====
// Iterative 32-bit integer divider with RISC-V corner-case results.
// Pulse start while busy is low; result is valid while done is high.
// done_early marks an answer taken from the small-number path.

module div_top #(
   parameter int DATA_W = 32
) (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           start,
   input  logic           unsigned_op,
   input  logic           rem_op,
   input  div_pkg::word_t dividend,
   input  div_pkg::word_t divisor,
   input  logic           fast_disable,
   output logic           busy,
   output logic           done,
   output logic           done_early,
   output div_pkg::word_t result
);
   import div_pkg::*;

   // Operand captures
   word_t mag_dividend;
   ext_t  m_reg;
   logic  neg_q;
   logic  neg_r;
   logic  rem_sel;

   // Datapath results
   word_t quotient;
   word_t remainder;
   nib_t  small_q;

   div_ctrl_if ctrl_if ();

   div_ctl u_ctl (
      .clk          (clk),
      .arst_n       (arst_n),
      .start        (start),
      .fast_disable (fast_disable),
      .rem_op       (rem_op),
      .ctrl         (ctrl_if.ctl),
      .busy         (busy),
      .done         (done),
      .done_early   (done_early)
   );

   div_operands #(.DATA_W(DATA_W)) u_operands (
      .clk          (clk),
      .arst_n       (arst_n),
      .dividend     (dividend),
      .divisor      (divisor),
      .unsigned_op  (unsigned_op),
      .rem_op       (rem_op),
      .ctrl         (ctrl_if.dp),
      .mag_dividend (mag_dividend),
      .m_reg        (m_reg),
      .neg_q        (neg_q),
      .neg_r        (neg_r),
      .rem_sel      (rem_sel)
   );

   div_iterate #(.DATA_W(DATA_W)) u_iterate (
      .clk          (clk),
      .arst_n       (arst_n),
      .mag_dividend (mag_dividend),
      .m_reg        (m_reg),
      .ctrl         (ctrl_if.dp),
      .quotient     (quotient),
      .remainder    (remainder)
   );

   div_smallnum u_smallnum (
      .clk          (clk),
      .arst_n       (arst_n),
      .mag_dividend (mag_dividend),
      .m_reg        (m_reg),
      .small_q      (small_q)
   );

   div_result #(.DATA_W(DATA_W)) u_result (
      .quotient     (quotient),
      .remainder    (remainder),
      .small_q      (small_q),
      .neg_q        (neg_q),
      .neg_r        (neg_r),
      .rem_sel      (rem_sel),
      .ctrl         (ctrl_if.dp),
      .result       (result)
   );

endmodule

// ==== bench/div_assert.sv ====
// Protocol checks on the divider FSM, bound into div_ctl by the testbench.
// Watches start, busy, done and done_early against the FSM state.

module div_assert (
   input logic                clk,
   input logic                arst_n,
   input logic                start,
   input logic                busy,
   input logic                done,
   input logic                done_early,
   input div_pkg::div_state_t state
);
   import div_pkg::*;

   // A start during an operation must not reload the FSM
   a_start_while_busy: assert property (
      @(posedge clk) disable iff (!arst_n)
         (busy && start) |=> (state != LOAD)
   ) else $error("start was taken while the divider was busy");

   // Single-cycle done pulse
   a_done_pulse: assert property (
      @(posedge clk) disable iff (!arst_n)
         done |=> !done
   ) else $error("done stayed high for more than one cycle");

   a_early_with_done: assert property (
      @(posedge clk) disable iff (!arst_n)
         done_early |-> done
   ) else $error("done_early was high without done");

   // Back to idle right after the answer
   a_busy_falls: assert property (
      @(posedge clk) disable iff (!arst_n)
         done |=> !busy
   ) else $error("busy did not fall after done");

endmodule

// ==== bench/div_tb.sv ====
// Self-checking testbench for the iterative divider.
// Drives directed corner cases and LFSR-based random operations, checks
// results and latency against a RISC-V division model.

module div_tb;
   import div_pkg::*;

   localparam int          NUM_TESTS    = 300;
   localparam int          NUM_DIRECTED = 9;
   localparam int          CLK_PERIOD   = 20;
   localparam int          OP_CYCLES    = 40;
   localparam logic [31:0] SEED         = 32'h6f49f637;

   logic  clk;
   logic  arst_n;
   logic  start;
   logic  unsigned_op;
   logic  rem_op;
   logic  fast_disable;
   word_t dividend;
   word_t divisor;
   logic  busy;
   logic  done;
   logic  done_early;
   word_t result;

   logic [31:0] lfsr;
   int          checks;
   int          errors;

   div_top #(.DATA_W(32)) dut (
      .clk          (clk),
      .arst_n       (arst_n),
      .start        (start),
      .unsigned_op  (unsigned_op),
      .rem_op       (rem_op),
      .dividend     (dividend),
      .divisor      (divisor),
      .fast_disable (fast_disable),
      .busy         (busy),
      .done         (done),
      .done_early   (done_early),
      .result       (result)
   );

   bind div_ctl div_assert u_assert (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .busy       (busy),
      .done       (done),
      .done_early (done_early),
      .state      (state)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic rand_bit();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   // RISC-V DIV/DIVU/REM/REMU
   function automatic logic [31:0] model_div(input logic [31:0] a, input logic [31:0] b,
                                             input logic uns, input logic rem);
      logic [31:0] q;
      logic [31:0] r;
      if (b == '0) begin
         q = '1;
         r = a;
      end else if (!uns && a == 32'h8000_0000 && b == '1) begin
         q = a;
         r = '0;
      end else if (uns) begin
         q = a / b;
         r = a % b;
      end else begin
         q = $signed(a) / $signed(b);
         r = $signed(a) % $signed(b);
      end
      return rem ? r : q;
   endfunction

   // Both operands within 4 bits and a non-zero divisor
   function automatic logic fits_small(input logic [31:0] a, input logic [31:0] b,
                                       input logic uns);
      logic [31:0] mag;
      mag = (!uns && a[31]) ? -a : a;
      return (mag < 32'd16) && (b < 32'd16) && (b != '0);
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic run_op(input string name, input word_t a, input word_t b, input logic uns,
                         input logic rem, input logic fdis, input logic poke);
      int   cycles;
      int   exp_cycles;
      logic fast;
      fast = fits_small(a, b, uns) && !rem && !fdis;
      exp_cycles = fast ? 2 : (rem ? 35 : 34);
      while (busy) @(negedge clk);
      start        = 1'b1;
      dividend     = a;
      divisor      = b;
      unsigned_op  = uns;
      rem_op       = rem;
      fast_disable = fdis;
      @(negedge clk);
      check_value({name, " busy"}, 32'd1, 32'(busy));
      // Operands only matter on the accepting edge
      start        = 1'b0;
      dividend     = ~a;
      divisor      = ~b;
      unsigned_op  = ~uns;
      rem_op       = ~rem;
      fast_disable = ~fdis;
      cycles = 1;
      while (!done) begin
         start = poke && (cycles == 3);
         @(negedge clk);
         cycles++;
      end
      start = 1'b0;
      check_value({name, " result"}, model_div(a, b, uns, rem), result);
      check_value({name, " latency"}, exp_cycles, cycles);
      check_value({name, " done_early"}, 32'(fast), 32'(done_early));
   endtask

   task automatic random_op(input int idx);
      word_t a;
      word_t b;
      int    kind;
      logic  uns;
      logic  rem;
      logic  fdis;
      logic  poke;
      kind = rand_bits(3);
      a = rand_bits(32);
      b = rand_bits(32);
      case (kind)
         3, 4: begin
            a = rand_bits(4);
            b = rand_bits(4);
            if (b == '0) b = 32'd1;
            if (rand_bit()) a = -a;
         end
         5: b = '0;
         6: begin
            a = 32'h8000_0000;
            b = '1;
         end
         7: begin
            b = rand_bits(8);
            if (rand_bit()) b = -b;
         end
         default: ;
      endcase
      uns  = rand_bit();
      rem  = rand_bit();
      fdis = (rand_bits(2) == '0);
      poke = (rand_bits(3) == '0);
      run_op($sformatf("random %0d", idx), a, b, uns, rem, fdis, poke);
   endtask

   initial begin
      #(CLK_PERIOD * ((NUM_TESTS + NUM_DIRECTED) * OP_CYCLES + 100));
      $display("Timeout: the divider did not finish all operations in time");
      $display("Test failed");
      $finish;
   end

   initial begin
      arst_n       = 1'b0;
      start        = 1'b0;
      unsigned_op  = 1'b0;
      rem_op       = 1'b0;
      fast_disable = 1'b0;
      dividend     = '0;
      divisor      = '0;
      lfsr         = SEED;
      checks       = 0;
      errors       = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("reset busy", 32'd0, 32'(busy));
      check_value("reset done", 32'd0, 32'(done));
      check_value("reset done_early", 32'd0, 32'(done_early));
      check_value("reset result", 32'd0, result);
      arst_n = 1'b1;
      @(negedge clk);

      // Fast path, its disabled twin and the remainder that never uses it
      run_op("small fast", 32'd13, 32'd4, 1'b0, 1'b0, 1'b0, 1'b0);
      run_op("small negative", -32'd13, 32'd3, 1'b0, 1'b0, 1'b0, 1'b0);
      run_op("small disabled", 32'd13, 32'd4, 1'b0, 1'b0, 1'b1, 1'b0);
      run_op("small remainder", 32'd13, 32'd4, 1'b0, 1'b1, 1'b0, 1'b0);
      run_op("zero divisor q", 32'h1234_5678, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
      run_op("zero divisor r", 32'h8765_4321, 32'd0, 1'b0, 1'b1, 1'b0, 1'b0);
      run_op("overflow q", 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0, 1'b0, 1'b0);
      run_op("overflow r", 32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, 1'b0, 1'b0);
      run_op("start while busy", 32'd1000, 32'd7, 1'b1, 1'b0, 1'b0, 1'b1);

      for (int i = 0; i < NUM_TESTS; i++) begin
         random_op(i);
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
logic/div_pkg.sv
logic/div_ctrl_if.sv
logic/div_ctl.sv
logic/div_operands.sv
logic/div_iterate.sv
logic/div_smallnum.sv
logic/div_result.sv
logic/div_top.sv
bench/div_assert.sv
bench/div_tb.sv

// ==== Makefile ====
# Verilator build and run for the divider testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = div_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
